// File: src/l2ic_config.svh
// sizing macros for cores, banks, address, data and bank depth
`ifndef L2IC_CONFIG_SVH
`define L2IC_CONFIG_SVH

// initiator ports
`define L2IC_N_CORES 4

// SRAM banks, keep a power of two
`define L2IC_N_BANKS 4

// byte address and data width
`define L2IC_AW 16
`define L2IC_DW 32

// words per bank
`define L2IC_BANK_WORDS 256

// words per block when block-interleaved
`define L2IC_BLOCK_WORDS 16

`endif

// File: src/l2ic_pkg.sv
// core, bank and config bus structs plus policy, interleave and register enums
`include "l2ic_config.svh"

package l2ic_pkg;

  typedef enum logic {
    ARB_RR    = 1'b0,
    ARB_FIXED = 1'b1
  } arb_policy_e;

  typedef enum logic {
    IL_WORD  = 1'b0,
    IL_BLOCK = 1'b1
  } interleave_e;

  typedef enum logic {
    CFG_ARB = 1'b0,
    CFG_IL  = 1'b1
  } cfg_addr_e;

  typedef struct packed {
    logic                    req;
    logic                    wen;    // 1 = read
    logic [`L2IC_AW-1:0]     addr;   // byte address
    logic [`L2IC_DW-1:0]     wdata;
    logic [`L2IC_DW/8-1:0]   be;
  } core_req_t;

  typedef struct packed {
    logic                gnt;
    logic                r_valid;
    logic [`L2IC_DW-1:0] r_rdata;
  } core_rsp_t;

  typedef struct packed {
    logic                                req;
    logic                                wen;
    logic [$clog2(`L2IC_BANK_WORDS)-1:0] index;  // word within the bank
    logic [`L2IC_DW-1:0]                 wdata;
    logic [`L2IC_DW/8-1:0]               be;
    logic [$clog2(`L2IC_N_CORES)-1:0]    id;     // requesting core
  } bank_req_t;

  typedef struct packed {
    logic                             r_valid;
    logic [`L2IC_DW-1:0]              r_rdata;
    logic [$clog2(`L2IC_N_CORES)-1:0] r_id;
  } bank_rsp_t;

  typedef struct packed {
    logic       we;
    cfg_addr_e  addr;
    logic [7:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic [7:0] rdata;
  } cfg_rsp_t;

  // settings handed to the crossbar
  typedef struct packed {
    arb_policy_e arb_policy;
    interleave_e interleave;
  } l2ic_ctrl_t;

endpackage

// File: src/l2ic_ctrl_regs.sv
// arbitration policy and interleave mode registers on the config bus
`include "l2ic_config.svh"

module l2ic_ctrl_regs (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  l2ic_pkg::cfg_req_t   cfg_req_i,
  output l2ic_pkg::cfg_rsp_t   cfg_rsp_o,
  output l2ic_pkg::l2ic_ctrl_t ctrl_o
);

  l2ic_pkg::arb_policy_e arb_q;
  l2ic_pkg::interleave_e il_q;

  // only bit 0 of wdata is meaningful for either register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      arb_q <= l2ic_pkg::ARB_RR;
      il_q  <= l2ic_pkg::IL_WORD;
    end else if (cfg_req_i.we) begin
      case (cfg_req_i.addr)
        l2ic_pkg::CFG_ARB: begin
          arb_q <= l2ic_pkg::arb_policy_e'(cfg_req_i.wdata[0]);
        end
        l2ic_pkg::CFG_IL: begin
          il_q <= l2ic_pkg::interleave_e'(cfg_req_i.wdata[0]);
        end
        default: begin
        end
      endcase
    end
  end

  // combinational read-back, zero-extended
  always_comb begin
    cfg_rsp_o.rdata = '0;
    case (cfg_req_i.addr)
      l2ic_pkg::CFG_ARB: begin
        cfg_rsp_o.rdata = {7'd0, arb_q};
      end
      l2ic_pkg::CFG_IL: begin
        cfg_rsp_o.rdata = {7'd0, il_q};
      end
      default: begin
        cfg_rsp_o.rdata = '0;
      end
    endcase
  end

  assign ctrl_o = '{arb_policy: arb_q, interleave: il_q};  // visible the cycle after a write

endmodule

// File: src/l2ic_bank_arbiter.sv
// per-bank arbiter over all cores with round-robin and fixed-priority modes
`include "l2ic_config.svh"

module l2ic_bank_arbiter (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  l2ic_pkg::arb_policy_e     policy_i,
  input  logic [`L2IC_N_CORES-1:0]  req_i,
  output logic [`L2IC_N_CORES-1:0]  gnt_o
);

  localparam int unsigned N  = `L2IC_N_CORES;
  localparam int unsigned IW = $clog2(N);

  logic [IW-1:0] ptr_q;    // rr search start
  logic [IW-1:0] fix_idx;
  logic [IW-1:0] rr_idx;
  logic [IW-1:0] win_idx;
  logic          any_req;

  assign any_req = |req_i;

  // lowest index wins; scanning downwards leaves the lowest one in place
  always_comb begin
    fix_idx = '0;
    for (int i = int'(N) - 1; i >= 0; i--) begin
      if (req_i[i]) begin
        fix_idx = IW'(i);
      end
    end
  end

  // first requester at or after the pointer, wrapping around
  always_comb begin : rr_pick
    int idx;
    rr_idx = '0;
    for (int k = int'(N) - 1; k >= 0; k--) begin
      idx = (int'(ptr_q) + k) % int'(N);
      if (req_i[idx]) begin
        rr_idx = IW'(idx);
      end
    end
  end

  assign win_idx = (policy_i == l2ic_pkg::ARB_FIXED) ? fix_idx : rr_idx;

  always_comb begin
    gnt_o = '0;
    if (any_req) begin
      gnt_o[win_idx] = 1'b1;  // one-hot
    end
  end

  // pointer moves one past the winner, rr mode only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (any_req && policy_i == l2ic_pkg::ARB_RR) begin
      if (win_idx == IW'(N - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= win_idx + IW'(1);
      end
    end
  end

endmodule

// File: src/l2ic_xbar.sv
// address decode, per-bank arbitration, ID tagging and response demux
`include "l2ic_config.svh"

module l2ic_xbar (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  l2ic_pkg::l2ic_ctrl_t                    ctrl_i,
  input  l2ic_pkg::core_req_t [`L2IC_N_CORES-1:0] core_req_i,
  output l2ic_pkg::core_rsp_t [`L2IC_N_CORES-1:0] core_rsp_o,
  output l2ic_pkg::bank_req_t [`L2IC_N_BANKS-1:0] bank_req_o,
  input  l2ic_pkg::bank_rsp_t [`L2IC_N_BANKS-1:0] bank_rsp_i
);

  localparam int unsigned NC  = `L2IC_N_CORES;
  localparam int unsigned NB  = `L2IC_N_BANKS;
  localparam int unsigned WAW = `L2IC_AW - 2;                // word address width
  localparam int unsigned BSW = $clog2(NB);
  localparam int unsigned IXW = $clog2(`L2IC_BANK_WORDS);
  localparam int unsigned OFW = $clog2(`L2IC_BLOCK_WORDS);   // word offset in a block
  localparam int unsigned IDW = $clog2(NC);

  logic                   blk_mode;
  logic [NC-1:0][WAW-1:0] waddr;
  logic [NC-1:0][BSW-1:0] tgt_bank;
  logic [NC-1:0][IXW-1:0] tgt_idx;
  logic [NB-1:0][NC-1:0]  arb_req;
  logic [NB-1:0][NC-1:0]  arb_gnt;

  assign blk_mode = (ctrl_i.interleave == l2ic_pkg::IL_BLOCK);

  // word mode: low word bits pick the bank
  // block mode: bits above the block offset pick it, offset stays in the index
  for (genvar c = 0; c < NC; c++) begin : g_decode
    assign waddr[c]    = core_req_i[c].addr[`L2IC_AW-1:2];
    assign tgt_bank[c] = blk_mode ? waddr[c][OFW +: BSW] : waddr[c][BSW-1:0];
    assign tgt_idx[c]  = blk_mode ? {waddr[c][OFW+BSW +: IXW-OFW], waddr[c][OFW-1:0]}
                                  : waddr[c][BSW +: IXW];
  end

  for (genvar b = 0; b < NB; b++) begin : g_bank
    for (genvar c = 0; c < NC; c++) begin : g_req
      assign arb_req[b][c] = core_req_i[c].req && (tgt_bank[c] == BSW'(b));
    end

    l2ic_bank_arbiter u_arb (
      .clk_i    ( clk_i             ),
      .rst_ni   ( rst_ni            ),
      .policy_i ( ctrl_i.arb_policy ),
      .req_i    ( arb_req[b]        ),
      .gnt_o    ( arb_gnt[b]        )
    );
  end

  // winner onto each bank, tagged with its core index
  always_comb begin
    bank_req_o = '0;
    for (int b = 0; b < int'(NB); b++) begin
      for (int c = 0; c < int'(NC); c++) begin
        if (arb_gnt[b][c]) begin
          bank_req_o[b].req   = 1'b1;
          bank_req_o[b].wen   = core_req_i[c].wen;
          bank_req_o[b].index = tgt_idx[c];
          bank_req_o[b].wdata = core_req_i[c].wdata;
          bank_req_o[b].be    = core_req_i[c].be;
          bank_req_o[b].id    = IDW'(c);
        end
      end
    end
  end

  // gnt back to the cores, responses steered by r_id
  always_comb begin
    core_rsp_o = '0;
    for (int c = 0; c < int'(NC); c++) begin
      for (int b = 0; b < int'(NB); b++) begin
        if (arb_gnt[b][c]) begin
          core_rsp_o[c].gnt = 1'b1;
        end
        // at most one bank answers a given core per cycle
        if (bank_rsp_i[b].r_valid && bank_rsp_i[b].r_id == IDW'(c)) begin
          core_rsp_o[c].r_valid = 1'b1;
          core_rsp_o[c].r_rdata = bank_rsp_i[b].r_rdata;
        end
      end
    end
  end

endmodule

// File: src/l2ic_sram_bank.sv
// word-wide SRAM bank with byte enables and a registered one-cycle read response
`include "l2ic_config.svh"

module l2ic_sram_bank (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  l2ic_pkg::bank_req_t bank_req_i,
  output l2ic_pkg::bank_rsp_t bank_rsp_o
);

  localparam int unsigned DW  = `L2IC_DW;
  localparam int unsigned NW  = `L2IC_BANK_WORDS;
  localparam int unsigned IDW = $clog2(`L2IC_N_CORES);

  logic [DW-1:0]  mem_q [NW];
  logic           rd_en;
  logic           wr_en;
  logic           r_valid_q;
  logic [DW-1:0]  r_rdata_q;
  logic [IDW-1:0] r_id_q;

  assign rd_en = bank_req_i.req & bank_req_i.wen;   // wen high means read
  assign wr_en = bank_req_i.req & ~bank_req_i.wen;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int i = 0; i < int'(DW / 8); i++) begin
        if (bank_req_i.be[i]) begin
          mem_q[bank_req_i.index][8*i +: 8] <= bank_req_i.wdata[8*i +: 8];
        end
      end
    end
    if (rd_en) begin
      r_rdata_q <= mem_q[bank_req_i.index];
      r_id_q    <= bank_req_i.id;  // echoed for the demux
    end
  end

  // strobe only for reads, writes stay silent
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= rd_en;
    end
  end

  assign bank_rsp_o = '{r_valid: r_valid_q, r_rdata: r_rdata_q, r_id: r_id_q};

endmodule

// File: src/l2ic_top.sv
// L2 log interconnect top with config registers, crossbar and bank array
`include "l2ic_config.svh"

module l2ic_top (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  l2ic_pkg::cfg_req_t                      cfg_req_i,
  output l2ic_pkg::cfg_rsp_t                      cfg_rsp_o,
  input  l2ic_pkg::core_req_t [`L2IC_N_CORES-1:0] core_req_i,
  output l2ic_pkg::core_rsp_t [`L2IC_N_CORES-1:0] core_rsp_o
);

  localparam int unsigned NB = `L2IC_N_BANKS;

  l2ic_pkg::l2ic_ctrl_t          ctrl;      // policy and interleave to the crossbar
  l2ic_pkg::bank_req_t [NB-1:0]  bank_req;
  l2ic_pkg::bank_rsp_t [NB-1:0]  bank_rsp;

  l2ic_ctrl_regs u_ctrl_regs (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .cfg_req_i ( cfg_req_i ),
    .cfg_rsp_o ( cfg_rsp_o ),
    .ctrl_o    ( ctrl      )
  );

  l2ic_xbar u_xbar (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ctrl_i     ( ctrl       ),
    .core_req_i ( core_req_i ),
    .core_rsp_o ( core_rsp_o ),
    .bank_req_o ( bank_req   ),
    .bank_rsp_i ( bank_rsp   )
  );

  // one SRAM per bank, no refusal path
  for (genvar b = 0; b < NB; b++) begin : g_bank
    l2ic_sram_bank u_bank (
      .clk_i      ( clk_i       ),
      .rst_ni     ( rst_ni      ),
      .bank_req_i ( bank_req[b] ),
      .bank_rsp_o ( bank_rsp[b] )
    );
  end

endmodule

// File: test/tb_l2ic.sv
// testbench for the L2 interconnect, driven by a pattern file with a shadow memory
`include "l2ic_config.svh"

module tb_l2ic;

  localparam int NC = `L2IC_N_CORES;

  logic                         clk_i;
  logic                         rst_ni;
  l2ic_pkg::cfg_req_t           cfg_req;
  l2ic_pkg::cfg_rsp_t           cfg_rsp;
  l2ic_pkg::core_req_t [NC-1:0] core_req;
  l2ic_pkg::core_rsp_t [NC-1:0] core_rsp;

  // requests queued for the next group
  logic [NC-1:0] q_mask;
  logic [NC-1:0] q_wen;
  logic [15:0]   q_addr [NC];
  logic [31:0]   q_wdata [NC];
  logic [3:0]    q_be [NC];
  int            q_gcyc [NC];   // expected grant cycle within the group
  int            q_src [NC];    // 0 none, 1 file, 2 shadow
  logic [31:0]   q_exp [NC];

  logic [31:0] shadow [int];    // keyed by byte address
  integer      seed;
  int          errors;
  int          checks;
  bit          abort;

  l2ic_top u_dut (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .cfg_req_i  ( cfg_req  ),
    .cfg_rsp_o  ( cfg_rsp  ),
    .core_req_i ( core_req ),
    .core_rsp_o ( core_rsp )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Fail %s got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] apply_be(input logic [31:0] old, input logic [31:0] nw,
                                           input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = nw[8*i +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] shadow_word(input logic [15:0] a);
    return shadow.exists(int'(a)) ? shadow[int'(a)] : 32'h0;
  endfunction

  task automatic queue_req(input int c, input logic wen, input logic [15:0] addr,
                           input logic [31:0] wdata, input logic [3:0] be,
                           input int gcyc, input int src, input logic [31:0] exp);
    q_mask[c]  = 1'b1;
    q_wen[c]   = wen;
    q_addr[c]  = addr;
    q_wdata[c] = wdata;
    q_be[c]    = be;
    q_gcyc[c]  = gcyc;
    q_src[c]   = src;
    q_exp[c]   = exp;
  endtask

  // issue all queued requests together and follow them to completion
  task automatic run_group();
    logic [NC-1:0] waiting;
    logic [NC-1:0] rd_due;    // read granted in the previous cycle
    logic [NC-1:0] rd_next;
    logic [31:0]   rd_exp [NC];
    bit            settle;
    int            cyc;
    waiting = q_mask;
    rd_due  = '0;
    settle  = 1'b0;
    cyc     = 0;
    for (int c = 0; c < NC; c++) begin
      if (q_mask[c]) begin
        core_req[c].req   = 1'b1;
        core_req[c].wen   = q_wen[c];
        core_req[c].addr  = q_addr[c];
        core_req[c].wdata = q_wdata[c];
        core_req[c].be    = q_be[c];
      end
    end
    while ((waiting != '0 || settle) && !abort) begin
      @(negedge clk_i);
      rd_next = '0;
      settle  = 1'b0;
      for (int c = 0; c < NC; c++) begin
        check_val($sformatf("core_rsp_o[%0d].gnt", c), 32'(core_rsp[c].gnt),
                  32'(waiting[c] && cyc == q_gcyc[c]));
        check_val($sformatf("core_rsp_o[%0d].r_valid", c), 32'(core_rsp[c].r_valid),
                  32'(rd_due[c]));
        if (rd_due[c]) begin
          check_val($sformatf("core_rsp_o[%0d].r_rdata", c), core_rsp[c].r_rdata, rd_exp[c]);
        end
        if (waiting[c] && core_rsp[c].gnt) begin
          waiting[c] = 1'b0;
          settle     = 1'b1;
          if (q_wen[c]) begin
            rd_next[c] = 1'b1;
            rd_exp[c]  = (q_src[c] == 2) ? shadow_word(q_addr[c]) : q_exp[c];
          end else begin
            shadow[int'(q_addr[c])] = apply_be(shadow_word(q_addr[c]), q_wdata[c], q_be[c]);
          end
        end
      end
      rd_due = rd_next;
      @(posedge clk_i);
      #2;
      for (int c = 0; c < NC; c++) begin
        if (q_mask[c] && !waiting[c]) begin
          core_req[c].req = 1'b0;  // free to go after gnt
        end
      end
      cyc++;
      if (cyc >= 50 && waiting != '0) begin
        $display("timeout: core requests were not granted within 50 cycles");
        errors++;
        abort = 1'b1;
      end
    end
    q_mask = '0;
  endtask

  task automatic cfg_write(input logic a, input logic [7:0] d);
    cfg_req.we    = 1'b1;
    cfg_req.addr  = l2ic_pkg::cfg_addr_e'(a);
    cfg_req.wdata = d;
    @(posedge clk_i);
    #2;
    cfg_req.we = 1'b0;
    if (a) begin
      shadow.delete();  // new bank layout, old contents no longer line up
    end
  endtask

  task automatic cfg_read(input logic a, input logic [7:0] exp);
    cfg_req.addr = l2ic_pkg::cfg_addr_e'(a);
    @(negedge clk_i);
    check_val("cfg_rsp_o.rdata", 32'(cfg_rsp.rdata), 32'(exp));
    @(posedge clk_i);
    #2;
  endtask

  // random word writes below 4 KiB, then read every one back
  task automatic random_fill(input int n);
    logic [15:0] addrs [$];
    logic [15:0] a;
    for (int i = 0; i < n; i++) begin
      a = 16'($random(seed)) & 16'h0ffc;
      addrs.push_back(a);
      queue_req(i % NC, 1'b0, a, $random(seed), 4'hf, 0, 0, '0);
      run_group();
    end
    foreach (addrs[i]) begin
      queue_req(i % NC, 1'b1, addrs[i], '0, 4'h0, 0, 2, '0);
      run_group();
    end
  endtask

  initial begin : main
    integer      fd;
    string       line;
    byte         op;
    int          nf;
    int          c;
    int          wen;
    int          gcyc;
    int          src;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] be;
    logic [31:0] exp;
    seed     = 32'h2cee2ba2;
    errors   = 0;
    checks   = 0;
    abort    = 1'b0;
    q_mask   = '0;
    cfg_req  = '0;
    core_req = '0;
    rst_ni   = 1'b0;
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    for (int i = 0; i < NC; i++) begin
      check_val($sformatf("core_rsp_o[%0d].gnt", i), 32'(core_rsp[i].gnt), '0);
      check_val($sformatf("core_rsp_o[%0d].r_valid", i), 32'(core_rsp[i].r_valid), '0);
    end
    @(posedge clk_i);
    #2;
    fd = $fopen("test/l2ic_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file test/l2ic_patterns.txt");
      errors++;
    end else begin
      while (!$feof(fd) && !abort) begin
        line = "";
        nf   = $fgets(line, fd);
        if (line.len() > 0) begin
          op = line[0];
          case (op)
            "W": begin
              nf = $sscanf(line.substr(1, line.len() - 1), "%h %h", addr, wdata);
              cfg_write(addr[0], wdata[7:0]);
            end
            "R": begin
              nf = $sscanf(line.substr(1, line.len() - 1), "%h %h", addr, exp);
              cfg_read(addr[0], exp[7:0]);
            end
            "Q": begin
              nf = $sscanf(line.substr(1, line.len() - 1), "%d %d %h %h %h %d %d %h",
                           c, wen, addr, wdata, be, gcyc, src, exp);
              if (nf != 8) begin
                $display("malformed request line in the pattern file: %s", line);
                errors++;
              end else begin
                queue_req(c, wen[0], addr[15:0], wdata, be[3:0], gcyc, src, exp);
              end
            end
            "G": run_group();
            "F": begin
              nf = $sscanf(line.substr(1, line.len() - 1), "%d", c);
              random_fill(c);
            end
            default: begin  // comments and blank lines
            end
          endcase
        end
      end
      $fclose(fd);
    end
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+src
src/l2ic_pkg.sv
src/l2ic_ctrl_regs.sv
src/l2ic_bank_arbiter.sv
src/l2ic_xbar.sv
src/l2ic_sram_bank.sv
src/l2ic_top.sv
test/tb_l2ic.sv

// File: Makefile
TOP := tb_l2ic

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/l2ic_patterns.txt
# Q <core> <wen 1=read> <addr> <wdata> <be> <gnt cycle> <exp src 0 none 1 file 2 shadow> <exp>
# W <cfg addr> <data>, R <cfg addr> <exp>, G issues queued requests, F <n> random fill
R 0 00
R 1 00
# round robin on bank 1, pointer starts at 0
Q 1 0 0204 11111111 f 0 0 0
Q 2 0 0214 22222222 f 1 0 0
G
Q 3 1 0204 0 0 0 1 11111111
Q 0 1 0214 0 0 1 1 22222222
Q 1 0 0224 33333333 f 2 0 0
Q 2 0 0234 44444444 f 3 0 0
G
# single core with byte enables
Q 0 0 0010 11223344 f 0 0 0
G
Q 0 0 0010 aabbccdd 5 0 0 0
G
Q 0 1 0010 0 0 0 1 11bb33dd
G
# four cores on four banks
Q 0 0 0100 a0a0a0a0 f 0 0 0
Q 1 0 0104 b1b1b1b1 f 0 0 0
Q 2 0 0108 c2c2c2c2 f 0 0 0
Q 3 0 010c d3d3d3d3 f 0 0 0
G
Q 0 1 010c 0 0 0 1 d3d3d3d3
Q 1 1 0108 0 0 0 1 c2c2c2c2
Q 2 1 0104 0 0 0 1 b1b1b1b1
Q 3 1 0100 0 0 0 1 a0a0a0a0
G
# fixed priority on bank 2
W 0 01
R 0 01
Q 0 0 0008 5a5a0000 f 0 0 0
Q 1 0 0018 5a5a0001 f 1 0 0
Q 2 0 0028 5a5a0002 f 2 0 0
Q 3 0 0038 5a5a0003 f 3 0 0
G
Q 0 1 0038 0 0 0 2 0
Q 1 1 0028 0 0 1 2 0
Q 2 1 0018 0 0 2 2 0
Q 3 1 0008 0 0 3 2 0
G
# block interleave, block 0x11 sits in bank 1
W 1 01
R 0 01
R 1 01
Q 0 0 0440 c0de0440 f 0 0 0
Q 1 0 0444 c0de0444 f 1 0 0
Q 2 0 0448 c0de0448 f 2 0 0
Q 3 0 044c c0de044c f 3 0 0
G
Q 2 1 0444 0 0 0 1 c0de0444
Q 3 1 0448 0 0 1 1 c0de0448
G
F 20
W 1 00
R 1 00
F 20
